//--- all.f
src/uart_pkg.sv
src/apb_uart_regs.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/apb_uart.sv
testbench/tb_clock.sv
testbench/tb_apb_uart.sv

//--- run.sh
#!/bin/sh
# Builds the APB UART testbench with Verilator, runs it and checks the log

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_apb_uart -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_apb_uart > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- src/apb_uart.sv
/*
 * APB UART top level
 * Register file, TX and RX FIFOs, transmitter and receiver
 */
`timescale 1ns/1ps

module apb_uart (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [uart_pkg::APB_ADDR_W-1:0] paddr_i,
    input  uart_pkg::apb_data_t             pwdata_i,
    output uart_pkg::apb_data_t             prdata_o,
    input  logic                            uart_rx_i,
    output logic                            uart_tx_o
);
    import uart_pkg::*;

    uart_data_t       tx_data;                   // Register file to TX FIFO
    logic             tx_valid;
    logic             tx_ready;
    uart_data_t       txf_data;                  // TX FIFO to transmitter
    logic             txf_valid;
    logic             txf_ready;
    uart_data_t       rxs_data;                  // Receiver to RX FIFO
    logic             rxs_valid;
    logic             rxs_ready;
    uart_data_t       rxf_data;                  // RX FIFO to register file
    logic             rxf_valid;
    logic             rxf_ready;
    logic             tx_reset;
    logic             rx_reset;
    logic             tx_path_rst;
    logic             rx_path_rst;
    logic             parity_err;
    parity_e          parity;
    logic [DIV_W-1:0] clk_div;

    assign tx_path_rst = rst_i | tx_reset;
    assign rx_path_rst = rst_i | rx_reset;

    apb_uart_regs u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .rx_data_i    (rxf_data),
        .rx_valid_i   (rxf_valid),
        .tx_empty_i   (~txf_valid),
        .tx_full_i    (~tx_ready),
        .rx_full_i    (~rxs_ready),
        .parity_err_i (parity_err),
        .prdata_o     (prdata_o),
        .tx_data_o    (tx_data),
        .tx_valid_o   (tx_valid),
        .rx_ready_o   (rxf_ready),
        .tx_reset_o   (tx_reset),
        .rx_reset_o   (rx_reset),
        .parity_o     (parity),
        .clk_div_o    (clk_div)
    );

    uart_fifo tx_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .clear_i   (tx_reset),
        .s_data_i  (tx_data),
        .s_valid_i (tx_valid),
        .s_ready_o (tx_ready),
        .m_data_o  (txf_data),
        .m_valid_o (txf_valid),
        .m_ready_i (txf_ready)
    );

    uart_fifo rx_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .clear_i   (rx_reset),
        .s_data_i  (rxs_data),
        .s_valid_i (rxs_valid),
        .s_ready_o (rxs_ready),
        .m_data_o  (rxf_data),
        .m_valid_o (rxf_valid),
        .m_ready_i (rxf_ready)
    );

    uart_tx u_tx (
        .clk_i     (clk_i),
        .rst_i     (tx_path_rst),
        .clk_div_i (clk_div),
        .parity_i  (parity),
        .s_data_i  (txf_data),
        .s_valid_i (txf_valid),
        .s_ready_o (txf_ready),
        .uart_tx_o (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i        (clk_i),
        .rst_i        (rx_path_rst),
        .clk_div_i    (clk_div),
        .parity_i     (parity),
        .uart_rx_i    (uart_rx_i),
        .m_data_o     (rxs_data),
        .m_valid_o    (rxs_valid),
        .m_ready_i    (rxs_ready),
        .parity_err_o (parity_err)
    );

endmodule

//--- src/apb_uart_regs.sv
/*
 * APB register file of the UART
 * Control and divider registers, status word and read mux
 * Single-cycle TX push and RX pop strobes
 */
`timescale 1ns/1ps

module apb_uart_regs (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               psel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  logic [uart_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  uart_pkg::apb_data_t                pwdata_i,
    input  uart_pkg::uart_data_t               rx_data_i,
    input  logic                               rx_valid_i,
    input  logic                               tx_empty_i,
    input  logic                               tx_full_i,
    input  logic                               rx_full_i,
    input  logic                               parity_err_i,
    output uart_pkg::apb_data_t                prdata_o,
    output uart_pkg::uart_data_t               tx_data_o,
    output logic                               tx_valid_o,
    output logic                               rx_ready_o,
    output logic                               tx_reset_o,
    output logic                               rx_reset_o,
    output uart_pkg::parity_e                  parity_o,
    output logic [uart_pkg::DIV_W-1:0]         clk_div_o
);
    import uart_pkg::*;

    logic              access;
    logic              wr_en;
    logic              rd_en;
    reg_addr_e         addr;
    logic [CTRL_W-1:0] ctrl_q;
    logic [DIV_W-1:0]  div_q;
    apb_data_t         status;

    assign access = psel_i & penable_i;          // Access phase, no wait states
    assign wr_en  = access & pwrite_i;
    assign rd_en  = access & ~pwrite_i;
    assign addr   = reg_addr_e'(paddr_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q <= CTRL_RESET;
            div_q  <= CLK_DIV_RESET;
        end else if (wr_en) begin
            case (addr)
                REG_CTRL:    ctrl_q <= pwdata_i[CTRL_W-1:0];
                REG_CLK_DIV: div_q  <= pwdata_i[DIV_W-1:0];
                default:     ;
            endcase
        end
    end

    assign tx_reset_o = ctrl_q[0];
    assign rx_reset_o = ctrl_q[1];
    assign clk_div_o  = div_q;

    // Odd wins when both parity bits are set
    always_comb begin
        if (ctrl_q[3]) begin
            parity_o = PAR_ODD;
        end else if (ctrl_q[2]) begin
            parity_o = PAR_EVEN;
        end else begin
            parity_o = PAR_NONE;
        end
    end

    assign tx_data_o  = pwdata_i[DATA_W-1:0];
    assign tx_valid_o = wr_en & (addr == REG_TX_DATA);
    assign rx_ready_o = rd_en & (addr == REG_RX_DATA);   // Pops only when the head is valid

    always_comb begin
        status    = '0;
        status[0] = ~rx_valid_i;                 // rx_empty
        status[1] = tx_empty_i;
        status[2] = rx_full_i;
        status[3] = tx_full_i;
        status[4] = parity_err_i;
    end

    always_comb begin
        case (addr)
            REG_CTRL:    prdata_o = apb_data_t'(ctrl_q);
            REG_CLK_DIV: prdata_o = apb_data_t'(div_q);
            REG_STATUS:  prdata_o = status;
            REG_RX_DATA: prdata_o = rx_valid_i ? apb_data_t'(rx_data_i) : '0;
            default:     prdata_o = '0;      // TX data is write only
        endcase
    end

endmodule

//--- src/uart_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO
 * Valid/ready on both sides, soft clear
 */
`timescale 1ns/1ps

module uart_fifo (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 clear_i,
    input  uart_pkg::uart_data_t s_data_i,
    input  logic                 s_valid_i,
    output logic                 s_ready_o,
    output uart_pkg::uart_data_t m_data_o,
    output logic                 m_valid_o,
    input  logic                 m_ready_i
);
    import uart_pkg::*;

    localparam logic [FIFO_PTR_W:0] FULL_CNT = (FIFO_PTR_W + 1)'(FIFO_DEPTH);

    uart_data_t            mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W:0]   count_q;
    logic                  push;
    logic                  pop;

    assign s_ready_o = (count_q != FULL_CNT);
    assign m_valid_o = (count_q != '0);
    assign m_data_o  = mem_q[rd_ptr_q];          // Head shows without a read strobe
    assign push      = s_valid_i & s_ready_o;
    assign pop       = m_valid_o & m_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= s_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;     // Depth is a power of two
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- src/uart_pkg.sv
/*
 * UART package
 * Widths, FIFO depth and register map of the APB UART
 * Parity and serial FSM enums, character and APB word types
 * Reset values of the control and divider registers
 */
package uart_pkg;

    localparam int DATA_W     = 8;               // Bits per character
    localparam int FIFO_DEPTH = 16;              // Entries per FIFO
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int APB_ADDR_W = 5;
    localparam int APB_DATA_W = 32;
    localparam int DIV_W      = 16;              // Bit period divider width
    localparam int CTRL_W     = 4;               // Defined bits of REG_CTRL

    typedef logic [DATA_W-1:0]     uart_data_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CTRL    = 5'h00,                     // tx_reset, rx_reset, parity_even, parity_odd
        REG_CLK_DIV = 5'h04,
        REG_STATUS  = 5'h08,                     // rx_empty, tx_empty, rx_full, tx_full, parity_err
        REG_TX_DATA = 5'h0C,
        REG_RX_DATA = 5'h10
    } reg_addr_e;

    typedef enum logic [1:0] {
        PAR_NONE = 2'd0,
        PAR_EVEN = 2'd1,
        PAR_ODD  = 2'd2
    } parity_e;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_START  = 3'd1,
        ST_DATA   = 3'd2,
        ST_PARITY = 3'd3,
        ST_STOP   = 3'd4
    } uart_state_e;

    localparam logic [CTRL_W-1:0] CTRL_RESET    = '0;
    localparam logic [DIV_W-1:0]  CLK_DIV_RESET = 16'd15;

endpackage

//--- src/uart_rx.sv
/*
 * UART receiver
 * Two-flop line synchronizer, start edge detect, mid-bit sampling
 * Parity check with sticky error flag, one-entry output holding
 */
`timescale 1ns/1ps

module uart_rx (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [uart_pkg::DIV_W-1:0] clk_div_i,
    input  uart_pkg::parity_e          parity_i,
    input  logic                       uart_rx_i,
    output uart_pkg::uart_data_t       m_data_o,
    output logic                       m_valid_o,
    input  logic                       m_ready_i,
    output logic                       parity_err_o
);
    import uart_pkg::*;

    localparam int               IDX_W    = $clog2(DATA_W);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_W - 1);

    logic             rx_meta_q;
    logic             rx_sync_q;
    logic             rx_prev_q;
    uart_state_e      state_q;
    logic [DIV_W-1:0] cnt_q;
    logic [DIV_W-1:0] half_div;
    logic [IDX_W-1:0] bit_idx_q;
    uart_data_t       shift_q;
    uart_data_t       data_q;
    logic             valid_q;
    logic             par_q;
    logic             par_en_q;
    logic             perr_q;
    logic             bit_end;

    assign half_div     = clk_div_i >> 1;
    assign bit_end      = (cnt_q == clk_div_i);
    assign m_data_o     = data_q;
    assign m_valid_o    = valid_q;
    assign parity_err_o = perr_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= uart_rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;              // Edge detect only
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            valid_q   <= 1'b0;
            par_q     <= 1'b0;
            par_en_q  <= 1'b0;
            perr_q    <= 1'b0;
        end else begin
            if (valid_q && m_ready_i) begin
                valid_q <= 1'b0;
            end
            if (state_q != ST_IDLE) begin
                cnt_q <= cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (rx_prev_q && !rx_sync_q) begin
                        par_q    <= (parity_i == PAR_ODD);
                        par_en_q <= (parity_i != PAR_NONE);
                        state_q  <= ST_START;
                    end
                end
                ST_START: begin
                    if (cnt_q == half_div) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        state_q   <= rx_sync_q ? ST_IDLE : ST_DATA;   // Glitch is a false start
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        shift_q <= {rx_sync_q, shift_q[DATA_W-1:1]};
                        par_q   <= par_q ^ rx_sync_q;
                        if (bit_idx_q == LAST_IDX) begin
                            state_q <= par_en_q ? ST_PARITY : ST_STOP;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                end
                ST_PARITY: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        state_q <= ST_STOP;
                        if (rx_sync_q != par_q) begin
                            perr_q <= 1'b1;      // Sticky until reset
                        end
                    end
                end
                ST_STOP: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        state_q <= ST_IDLE;
                        // Previous byte still pending means this one is lost
                        if (!valid_q || m_ready_i) begin
                            data_q  <= shift_q;
                            valid_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- src/uart_tx.sv
/*
 * UART transmitter
 * Start bit, LSB-first data, optional parity, one stop bit
 */
`timescale 1ns/1ps

module uart_tx (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [uart_pkg::DIV_W-1:0] clk_div_i,
    input  uart_pkg::parity_e          parity_i,
    input  uart_pkg::uart_data_t       s_data_i,
    input  logic                       s_valid_i,
    output logic                       s_ready_o,
    output logic                       uart_tx_o
);
    import uart_pkg::*;

    localparam int               IDX_W    = $clog2(DATA_W);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_W - 1);

    uart_state_e      state_q;
    logic [DIV_W-1:0] cnt_q;
    logic [IDX_W-1:0] bit_idx_q;
    uart_data_t       shift_q;
    logic             par_q;
    logic             par_en_q;
    logic             tx_q;
    logic             bit_end;

    assign bit_end   = (cnt_q == clk_div_i);
    assign s_ready_o = (state_q == ST_IDLE);
    assign uart_tx_o = tx_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            par_q     <= 1'b0;
            par_en_q  <= 1'b0;
            tx_q      <= 1'b1;                   // Line idles high
        end else begin
            if (state_q != ST_IDLE) begin
                cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (s_valid_i) begin
                        shift_q  <= s_data_i;
                        par_q    <= (parity_i == PAR_ODD);   // Odd parity seeds with 1
                        par_en_q <= (parity_i != PAR_NONE);
                        cnt_q    <= '0;
                        tx_q     <= 1'b0;
                        state_q  <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        tx_q      <= shift_q[0];
                        bit_idx_q <= '0;
                        state_q   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        par_q   <= par_q ^ shift_q[0];
                        shift_q <= shift_q >> 1;
                        if (bit_idx_q == LAST_IDX) begin
                            if (par_en_q) begin
                                tx_q    <= par_q ^ shift_q[0];
                                state_q <= ST_PARITY;
                            end else begin
                                tx_q    <= 1'b1;
                                state_q <= ST_STOP;
                            end
                        end else begin
                            tx_q      <= shift_q[1];
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                end
                ST_PARITY: begin
                    if (bit_end) begin
                        tx_q    <= 1'b1;
                        state_q <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (bit_end) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- testbench/tb_apb_uart.sv
/*
 * Testbench of the APB UART
 * APB read and write tasks, loopback select and frame injector
 * Reference model, compare tasks, per-test report and cycle timeout
 */
`timescale 1ns/1ps

module tb_apb_uart;
    import uart_pkg::*;

    localparam int NUM_FRAMES     = 8 + 16 + 1 + FIFO_DEPTH + 2;
    localparam int BIT_CYCLES     = int'(CLK_DIV_RESET) + 1;
    localparam int TIMEOUT_CYCLES = 12 * BIT_CYCLES * NUM_FRAMES + 2000;
    localparam apb_data_t CTRL_MASK = 32'h0000_000F;  // tx_reset, rx_reset, even, odd
    localparam apb_data_t DIV_MASK  = 32'h0000_FFFF;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    apb_data_t             pwdata;
    apb_data_t             prdata;
    logic                  uart_rx;
    logic                  uart_tx;
    logic                  loop_sel;
    logic                  inj_line;

    logic [31:0] lcg_state = 32'd92800;
    uart_data_t  exp_q[$];
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          test_base = 0;
    int          cycle_cnt = 0;

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    assign uart_rx = loop_sel ? uart_tx : inj_line;   // Loopback or injected frames

    apb_uart dut (
        .clk_i     (clk),
        .rst_i     (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .uart_rx_i (uart_rx),
        .uart_tx_o (uart_tx)
    );

    function automatic uart_data_t rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Parity bit that a correct sender puts on the line
    function automatic logic good_parity(uart_data_t b, parity_e mode);
        return (mode == PAR_ODD) ? ~(^b) : ^b;
    endfunction

    // Expected byte in the low bits, expected parity error on top
    function automatic logic [DATA_W:0] model_frame(uart_data_t sent, logic sent_par,
                                                    parity_e mode);
        logic perr;
        perr = (mode != PAR_NONE) && (sent_par != good_parity(sent, mode));
        return {perr, sent};
    endfunction

    function automatic apb_data_t expect_status(logic rx_empty, logic tx_empty, logic perr);
        apb_data_t w;
        w = '0;
        w[0] = rx_empty;
        w[1] = tx_empty;
        w[4] = perr;
        return w;
    endfunction

    task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input uart_data_t got, input uart_data_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data    = prdata;                        // Settled inside the access cycle
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_rx_byte();
        apb_data_t st;
        st = 32'h1;
        while (st[0]) begin
            apb_read(REG_STATUS, st);
        end
    endtask

    task automatic inject_frame(input uart_data_t b, input logic par_bit);
        logic [DATA_W+2:0] bits;
        bits = {1'b1, par_bit, b, 1'b0};         // Stop, parity, data, start
        @(negedge clk);
        for (int i = 0; i < DATA_W + 3; i++) begin
            inj_line = bits[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
    endtask

    task automatic run_loopback(input int n, input parity_e mode);
        uart_data_t      b;
        uart_data_t      exp_b;
        logic [DATA_W:0] exp;
        logic            perr_exp;
        apb_data_t       got;
        perr_exp = 1'b0;
        for (int i = 0; i < n; i++) begin
            b = rand_byte();
            exp = model_frame(b, good_parity(b, mode), mode);
            exp_q.push_back(exp[DATA_W-1:0]);
            perr_exp = perr_exp | exp[DATA_W];
            apb_write(REG_TX_DATA, apb_data_t'(b));
        end
        for (int i = 0; i < n; i++) begin
            wait_rx_byte();
            apb_read(REG_RX_DATA, got);
            exp_b = exp_q.pop_front();
            check_data("rx_data", got[DATA_W-1:0], exp_b);
        end
        apb_read(REG_STATUS, got);
        check_word("status", got, expect_status(1'b1, 1'b1, perr_exp));
    endtask

    task automatic finish_test(input int num, input string name);
        $display("Test %0d %s: %s", num, name, (err_cnt == test_base) ? "ok" : "failed");
        test_base = err_cnt;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        uart_data_t      b;
        uart_data_t      exp_b;
        logic            bad_par;
        logic [DATA_W:0] exp;
        apb_data_t       got;
        apb_data_t       st;
        int              rx_cnt;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        loop_sel = 1'b1;
        inj_line = 1'b1;
        wait (!rst);

        apb_read(REG_CTRL, got);
        check_word("ctrl", got, apb_data_t'(CTRL_RESET));
        apb_read(REG_CLK_DIV, got);
        check_word("clk_div", got, apb_data_t'(CLK_DIV_RESET));
        apb_read(REG_STATUS, got);
        check_word("status", got, expect_status(1'b1, 1'b1, 1'b0));
        finish_test(1, "reset values");

        apb_write(REG_CTRL, 32'hDEAD_BEEF);
        apb_read(REG_CTRL, got);
        check_word("ctrl", got, 32'hDEAD_BEEF & CTRL_MASK);
        apb_write(REG_CLK_DIV, 32'h1234_ABCD);
        apb_read(REG_CLK_DIV, got);
        check_word("clk_div", got, 32'h1234_ABCD & DIV_MASK);
        apb_read(5'h14, got);
        check_word("unmapped 0x14", got, '0);
        apb_read(5'h1C, got);
        check_word("unmapped 0x1C", got, '0);
        apb_write(REG_CTRL, apb_data_t'(CTRL_RESET));
        apb_write(REG_CLK_DIV, apb_data_t'(CLK_DIV_RESET));
        finish_test(2, "register read back");

        run_loopback(8, PAR_NONE);
        finish_test(3, "loopback no parity");

        apb_write(REG_CTRL, 32'h4);
        run_loopback(8, PAR_EVEN);
        apb_write(REG_CTRL, 32'h8);
        run_loopback(8, PAR_ODD);
        finish_test(4, "loopback even and odd parity");

        loop_sel = 1'b0;
        apb_write(REG_CTRL, 32'h4);
        b = rand_byte();
        bad_par = ~good_parity(b, PAR_EVEN);
        exp = model_frame(b, bad_par, PAR_EVEN);
        inject_frame(b, bad_par);
        wait_rx_byte();
        apb_read(REG_RX_DATA, got);
        check_data("rx_data", got[DATA_W-1:0], exp[DATA_W-1:0]);
        apb_read(REG_STATUS, got);
        check_word("status", got, expect_status(1'b1, 1'b1, exp[DATA_W]));
        apb_write(REG_CTRL, 32'h6);              // Pulse rx_reset
        apb_write(REG_CTRL, 32'h4);
        apb_read(REG_STATUS, got);
        check_word("status", got, expect_status(1'b1, 1'b1, 1'b0));
        finish_test(5, "injected parity error");

        apb_write(REG_CTRL, 32'h0);
        loop_sel = 1'b1;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            b = rand_byte();
            exp_q.push_back(b);
            apb_write(REG_TX_DATA, apb_data_t'(b));
        end
        apb_read(REG_STATUS, st);
        check_word("tx_full", apb_data_t'(st[3]), 32'h1);
        while (!st[1]) begin
            apb_read(REG_STATUS, st);
        end
        repeat (2 * 12 * BIT_CYCLES) @(posedge clk);   // Last frame reaches the RX side
        rx_cnt = 0;
        apb_read(REG_STATUS, st);
        while (!st[0]) begin
            apb_read(REG_RX_DATA, got);
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Error: received byte 0x%h that was never written", got[DATA_W-1:0]);
            end else begin
                exp_b = exp_q.pop_front();
                check_data("rx_data", got[DATA_W-1:0], exp_b);
            end
            rx_cnt++;
            apb_read(REG_STATUS, st);
        end
        if (rx_cnt == 0) begin
            err_cnt++;
            $display("No byte came back after the TX FIFO overflowed");
        end
        finish_test(6, "TX FIFO overflow");

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
/*
 * Testbench clock and reset
 * 10 ns clock, rst_o high for the first 3 cycles
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;                            // Released away from the active edge
    end

endmodule
